// File: src/router_pkg.sv
`default_nettype none

package router_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int NUM_PORTS      = 3;
    localparam int ADDR_WIDTH     = 2;
    localparam int LENGTH_WIDTH   = 6;
    localparam int FIFO_DEPTH     = 16;
    localparam int PTR_WIDTH      = 4;
    localparam int TIMEOUT_CYCLES = 30;
    localparam int TIMER_WIDTH    = 5;

    // Packet controller states
    typedef enum logic [2:0] {
        decode_address  = 3'd0,
        wait_empty      = 3'd1,
        load_first_data = 3'd2,
        load_data       = 3'd3,
        fifo_full_wait  = 3'd4,
        check_parity    = 3'd5
    } fsm_state_t;

    // Header byte as seen by the decoder
    typedef struct packed {
        logic [LENGTH_WIDTH-1:0] length;
        logic [ADDR_WIDTH-1:0]   addr;
    } header_fields_t;

    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        header_fields_t        fields;
    } packet_header_t;

endpackage

`default_nettype wire

// File: src/router_fifo.sv
`default_nettype none

module router_fifo (
    input  wire                              clock,
    input  wire                              resetn,
    input  wire                              soft_reset,
    input  wire                              write_enb,
    input  wire                              read_enb,
    input  wire  [router_pkg::DATA_WIDTH-1:0] data_in,
    output logic [router_pkg::DATA_WIDTH-1:0] data_out,
    output logic                             full,
    output logic                             empty
);

    logic [router_pkg::DATA_WIDTH-1:0] mem [router_pkg::FIFO_DEPTH];
    logic [router_pkg::PTR_WIDTH-1:0]  wr_ptr;
    logic [router_pkg::PTR_WIDTH-1:0]  rd_ptr;
    logic [router_pkg::PTR_WIDTH:0]    count;
    logic                              do_write;
    logic                              do_read;

    assign do_write = write_enb && !full;
    assign do_read  = read_enb && !empty;
    assign full     = (int'(count) == router_pkg::FIFO_DEPTH);
    assign empty    = (count == '0);

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers wrap naturally at the depth
    always_ff @(posedge clock) begin
        if (!resetn || soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Popped byte holds until the next pop
    always_ff @(posedge clock) begin
        if (!resetn || soft_reset) begin
            data_out <= '0;
        end else if (do_read) begin
            data_out <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (
        @(posedge clock) disable iff (!resetn)
        full |-> !write_enb
    ) else $error("write into a full FIFO");

endmodule

`default_nettype wire

// File: src/router_port_watch.sv
`default_nettype none

module router_port_watch (
    input  wire  clock,
    input  wire  resetn,
    input  wire  empty,
    input  wire  read_enb,
    output logic vld_out,
    output logic soft_reset
);

    logic [router_pkg::TIMER_WIDTH-1:0] timer;
    logic                               idle;
    logic                               expire;

    // Data waiting and nobody reading
    assign idle   = vld_out && !read_enb;
    assign expire = idle && (int'(timer) == router_pkg::TIMEOUT_CYCLES - 1);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            vld_out    <= 1'b0;
            soft_reset <= 1'b0;
            timer      <= '0;
        end else begin
            soft_reset <= expire;
            // Keep vld_out low until the flush has emptied the FIFO
            vld_out    <= !empty && !expire && !soft_reset;
            if (idle && !expire) begin
                timer <= timer + 1'b1;
            end else begin
                timer <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/router_sync.sv
`default_nettype none

module router_sync (
    input  wire                              clock,
    input  wire                              resetn,
    input  wire  [router_pkg::DATA_WIDTH-1:0] data_in,
    input  wire                              detect_add,
    input  wire                              packet_valid,
    input  wire                              write_enb_reg,
    input  wire                              empty_0,
    input  wire                              empty_1,
    input  wire                              empty_2,
    input  wire                              full_0,
    input  wire                              full_1,
    input  wire                              full_2,
    output logic [router_pkg::NUM_PORTS-1:0]  write_enb,
    output logic                             dest_empty,
    output logic                             dest_full
);

    router_pkg::packet_header_t        header;
    logic [router_pkg::ADDR_WIDTH-1:0] addr;

    assign header = data_in;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            addr <= '0;
        end else if (detect_add && packet_valid &&
                     int'(header.fields.addr) < router_pkg::NUM_PORTS) begin
            addr <= header.fields.addr;
        end
    end

    // Steer the write strobe to the latched port
    always_comb begin
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            write_enb[i] = write_enb_reg && (int'(addr) == i);
        end
    end

    always_comb begin
        case (addr)
            2'd0:    {dest_empty, dest_full} = {empty_0, full_0};
            2'd1:    {dest_empty, dest_full} = {empty_1, full_1};
            2'd2:    {dest_empty, dest_full} = {empty_2, full_2};
            default: {dest_empty, dest_full} = 2'b00;
        endcase
    end

endmodule

`default_nettype wire

// File: src/router_register.sv
`default_nettype none

module router_register (
    input  wire                              clock,
    input  wire                              resetn,
    input  wire                              packet_valid,
    input  wire  [router_pkg::DATA_WIDTH-1:0] data_in,
    input  wire                              detect_add,
    input  wire                              lfd_state,
    input  wire                              ld_state,
    input  wire                              rst_int_reg,
    output logic [router_pkg::DATA_WIDTH-1:0] dout,
    output logic                             err
);

    router_pkg::packet_header_t        header;
    logic [router_pkg::DATA_WIDTH-1:0] header_hold;
    logic [router_pkg::DATA_WIDTH-1:0] parity;
    logic                              mismatch;
    logic                              header_accept;

    assign header        = data_in;
    assign header_accept = detect_add && packet_valid &&
                           (int'(header.fields.addr) < router_pkg::NUM_PORTS);

    // Header held until the destination FIFO has drained
    always_ff @(posedge clock) begin
        if (header_accept) begin
            header_hold <= header.raw;
        end
    end

    // Running XOR, seeded with the header
    always_ff @(posedge clock) begin
        if (header_accept) begin
            parity <= header.raw;
        end else if (ld_state && packet_valid) begin
            parity <= parity ^ data_in;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            mismatch <= 1'b0;
            err      <= 1'b0;
        end else begin
            if (ld_state && !packet_valid) begin
                mismatch <= (parity != data_in);
            end
            if (header_accept) begin
                err <= 1'b0;
            end else if (rst_int_reg) begin
                err <= mismatch;
            end
        end
    end

    assign dout = lfd_state ? header_hold : data_in;

endmodule

`default_nettype wire

// File: src/router_fsm.sv
`default_nettype none

module router_fsm (
    input  wire                              clock,
    input  wire                              resetn,
    input  wire                              packet_valid,
    input  wire  [router_pkg::DATA_WIDTH-1:0] data_in,
    input  wire                              dest_empty,
    input  wire                              dest_full,
    output logic                             detect_add,
    output logic                             lfd_state,
    output logic                             ld_state,
    output logic                             write_enb_reg,
    output logic                             rst_int_reg,
    output logic                             busy
);

    router_pkg::fsm_state_t     state;
    router_pkg::fsm_state_t     next_state;
    router_pkg::packet_header_t header;

    assign header = data_in;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= router_pkg::decode_address;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            router_pkg::decode_address: begin
                // Address 3 has no port and is dropped here
                if (packet_valid && int'(header.fields.addr) < router_pkg::NUM_PORTS) begin
                    next_state = router_pkg::wait_empty;
                end
            end
            router_pkg::wait_empty: begin
                if (dest_empty) begin
                    next_state = router_pkg::load_first_data;
                end
            end
            router_pkg::load_first_data: begin
                next_state = router_pkg::load_data;
            end
            router_pkg::load_data: begin
                if (dest_full) begin
                    next_state = router_pkg::fifo_full_wait;
                end else if (!packet_valid) begin
                    // This byte was the parity byte
                    next_state = router_pkg::check_parity;
                end
            end
            router_pkg::fifo_full_wait: begin
                if (!dest_full) begin
                    next_state = router_pkg::load_data;
                end
            end
            router_pkg::check_parity: begin
                next_state = router_pkg::decode_address;
            end
            default: begin
                next_state = router_pkg::decode_address;
            end
        endcase
    end

    assign detect_add    = (state == router_pkg::decode_address);
    assign lfd_state     = (state == router_pkg::load_first_data);
    // Only counts as a load when the byte really goes into the FIFO
    assign ld_state      = (state == router_pkg::load_data) && !dest_full;
    assign write_enb_reg = lfd_state || ld_state;
    assign rst_int_reg   = (state == router_pkg::check_parity);

    // A full FIFO in load_data must also hold the sender, or its byte is lost
    assign busy = (state == router_pkg::wait_empty) ||
                  (state == router_pkg::load_first_data) ||
                  (state == router_pkg::fifo_full_wait) ||
                  (state == router_pkg::check_parity) ||
                  ((state == router_pkg::load_data) && dest_full);

    // The header always lands in a drained destination FIFO
    a_header_into_empty: assert property (
        @(posedge clock) disable iff (!resetn)
        (state == router_pkg::load_first_data) |-> dest_empty
    ) else $error("header written into a non-empty destination FIFO");

    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (!resetn)
        dest_full |-> !write_enb_reg
    ) else $error("write enable raised into a full destination FIFO");

endmodule

`default_nettype wire

// File: src/router_top.sv
`default_nettype none

module router_top (
    input  wire                              clock,
    input  wire                              resetn,
    input  wire                              packet_valid,
    input  wire  [router_pkg::DATA_WIDTH-1:0] data_in,
    input  wire                              read_enb_0,
    input  wire                              read_enb_1,
    input  wire                              read_enb_2,
    output logic [router_pkg::DATA_WIDTH-1:0] data_out_0,
    output logic [router_pkg::DATA_WIDTH-1:0] data_out_1,
    output logic [router_pkg::DATA_WIDTH-1:0] data_out_2,
    output logic                             vld_out_0,
    output logic                             vld_out_1,
    output logic                             vld_out_2,
    output logic                             err,
    output logic                             busy
);

    logic [router_pkg::DATA_WIDTH-1:0] dout;
    logic [router_pkg::NUM_PORTS-1:0]  write_enb;
    logic [router_pkg::NUM_PORTS-1:0]  soft_reset;
    logic [router_pkg::NUM_PORTS-1:0]  empty;
    logic [router_pkg::NUM_PORTS-1:0]  full;
    logic detect_add;
    logic lfd_state;
    logic ld_state;
    logic write_enb_reg;
    logic rst_int_reg;
    logic dest_empty;
    logic dest_full;

    router_fsm u_fsm (
        .clock(clock), .resetn(resetn), .packet_valid(packet_valid), .data_in(data_in),
        .dest_empty(dest_empty), .dest_full(dest_full), .detect_add(detect_add),
        .lfd_state(lfd_state), .ld_state(ld_state), .write_enb_reg(write_enb_reg),
        .rst_int_reg(rst_int_reg), .busy(busy)
    );

    router_register u_register (
        .clock(clock), .resetn(resetn), .packet_valid(packet_valid), .data_in(data_in),
        .detect_add(detect_add), .lfd_state(lfd_state), .ld_state(ld_state),
        .rst_int_reg(rst_int_reg), .dout(dout), .err(err)
    );

    router_sync u_sync (
        .clock(clock), .resetn(resetn), .data_in(data_in), .detect_add(detect_add),
        .packet_valid(packet_valid), .write_enb_reg(write_enb_reg),
        .empty_0(empty[0]), .empty_1(empty[1]), .empty_2(empty[2]),
        .full_0(full[0]), .full_1(full[1]), .full_2(full[2]),
        .write_enb(write_enb), .dest_empty(dest_empty), .dest_full(dest_full)
    );

    // One FIFO and one watchdog per output port
    router_fifo u_fifo_0 (
        .clock(clock), .resetn(resetn), .soft_reset(soft_reset[0]),
        .write_enb(write_enb[0]), .read_enb(read_enb_0), .data_in(dout),
        .data_out(data_out_0), .full(full[0]), .empty(empty[0])
    );

    router_fifo u_fifo_1 (
        .clock(clock), .resetn(resetn), .soft_reset(soft_reset[1]),
        .write_enb(write_enb[1]), .read_enb(read_enb_1), .data_in(dout),
        .data_out(data_out_1), .full(full[1]), .empty(empty[1])
    );

    router_fifo u_fifo_2 (
        .clock(clock), .resetn(resetn), .soft_reset(soft_reset[2]),
        .write_enb(write_enb[2]), .read_enb(read_enb_2), .data_in(dout),
        .data_out(data_out_2), .full(full[2]), .empty(empty[2])
    );

    router_port_watch u_watch_0 (
        .clock(clock), .resetn(resetn), .empty(empty[0]), .read_enb(read_enb_0),
        .vld_out(vld_out_0), .soft_reset(soft_reset[0])
    );

    router_port_watch u_watch_1 (
        .clock(clock), .resetn(resetn), .empty(empty[1]), .read_enb(read_enb_1),
        .vld_out(vld_out_1), .soft_reset(soft_reset[1])
    );

    router_port_watch u_watch_2 (
        .clock(clock), .resetn(resetn), .empty(empty[2]), .read_enb(read_enb_2),
        .vld_out(vld_out_2), .soft_reset(soft_reset[2])
    );

endmodule

`default_nettype wire

// File: verification/router_tb.sv
`default_nettype none

module router_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                              clock;
    logic                              resetn;
    logic                              packet_valid;
    logic [router_pkg::DATA_WIDTH-1:0] data_in;
    logic                              read_enb_0;
    logic                              read_enb_1;
    logic                              read_enb_2;
    logic [router_pkg::DATA_WIDTH-1:0] data_out_0;
    logic [router_pkg::DATA_WIDTH-1:0] data_out_1;
    logic [router_pkg::DATA_WIDTH-1:0] data_out_2;
    logic                              vld_out_0;
    logic                              vld_out_1;
    logic                              vld_out_2;
    logic                              err;
    logic                              busy;

    logic [15:0] lfsr;
    logic [7:0]  pkt [$];
    int          errors;
    int          sent;
    int          cycle_count = 0;

    router_top UUT (
        .clock(clock), .resetn(resetn), .packet_valid(packet_valid), .data_in(data_in),
        .read_enb_0(read_enb_0), .read_enb_1(read_enb_1), .read_enb_2(read_enb_2),
        .data_out_0(data_out_0), .data_out_1(data_out_1), .data_out_2(data_out_2),
        .vld_out_0(vld_out_0), .vld_out_1(vld_out_1), .vld_out_2(vld_out_2),
        .err(err), .busy(busy)
    );

    always #4 clock = ~clock;

    // Worst case of all tests is near 600 cycles, so 3000 leaves a wide margin
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 3000) begin
            $display("Timeout: the tests did not finish within 3000 clock cycles");
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    function automatic logic vld_of(input int port);
        case (port)
            0:       return vld_out_0;
            1:       return vld_out_1;
            default: return vld_out_2;
        endcase
    endfunction

    function automatic logic [7:0] dout_of(input int port);
        case (port)
            0:       return data_out_0;
            1:       return data_out_1;
            default: return data_out_2;
        endcase
    endfunction

    task automatic set_read(input int port, input logic value);
        case (port)
            0:       read_enb_0 <= value;
            1:       read_enb_1 <= value;
            default: read_enb_2 <= value;
        endcase
    endtask

    // Header, random payload, then the XOR of all of them
    task automatic build_packet(input logic [1:0] addr, input int len);
        logic [7:0] b;
        logic [7:0] par;
        pkt.delete();
        b = {len[5:0], addr};
        par = b;
        pkt.push_back(b);
        for (int i = 0; i < len; i++) begin
            rand_byte(b);
            par = par ^ b;
            pkt.push_back(b);
        end
        pkt.push_back(par);
    endtask

    // Called on a rising edge, returns on the edge that took the byte
    task automatic put_byte(input logic valid, input logic [7:0] b);
        logic taken;
        packet_valid <= valid;
        data_in      <= b;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = !busy;
            @(posedge clock);
        end
    endtask

    task automatic send_packet();
        sent = 0;
        foreach (pkt[i]) begin
            put_byte(i < pkt.size() - 1, pkt[i]);
            sent++;
        end
        packet_valid <= 1'b0;
        data_in      <= '0;
    endtask

    task automatic check_others(input int port);
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            if (p != port && vld_of(p)) begin
                errors++;
                $display("Fail at %0t: vld_out_%0d high during a packet to port %0d",
                         $time, p, port);
            end
        end
    endtask

    // One pop every three cycles so vld_out is never stale when sampled
    task automatic collect(input int port);
        int n;
        n = 0;
        while (n < pkt.size()) begin
            @(negedge clock);
            check_others(port);
            if (vld_of(port)) begin
                @(posedge clock);
                set_read(port, 1'b1);
                @(posedge clock);
                set_read(port, 1'b0);
                @(negedge clock);
                if (dout_of(port) !== pkt[n]) begin
                    errors++;
                    $display("Fail at %0t: port %0d byte %0d is %h, expected %h",
                             $time, port, n, dout_of(port), pkt[n]);
                end
                n++;
            end
        end
        @(negedge clock);
        if (vld_of(port)) begin
            errors++;
            $display("Fail at %0t: port %0d still valid after its packet", $time, port);
        end
        @(posedge clock);
    endtask

    task automatic check_err(input logic expected, input string what);
        @(negedge clock);
        if (err !== expected) begin
            errors++;
            $display("Fail at %0t: err is %b %s", $time, err, what);
        end
        @(posedge clock);
    endtask

    task automatic route_each_port();
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            build_packet(p[1:0], 5);
            send_packet();
            collect(p);
            check_err(1'b0, "after a packet with correct parity");
        end
    endtask

    task automatic bad_parity();
        build_packet(2'd0, 4);
        pkt[pkt.size()-1] = ~pkt[pkt.size()-1];
        send_packet();
        collect(0);
        check_err(1'b1, "after a packet with a wrong parity byte");
        build_packet(2'd0, 3);
        fork
            send_packet();
            begin
                // busy rises once the header is in
                do @(negedge clock); while (!busy);
                if (err) begin
                    errors++;
                    $display("Fail at %0t: err not cleared by a new header", $time);
                end
            end
        join
        collect(0);
        check_err(1'b0, "after a correct packet");
    endtask

    task automatic back_pressure();
        build_packet(2'd1, 20);
        fork
            send_packet();
            begin
                do @(negedge clock); while (!vld_out_1);
                // Well below the read timeout
                repeat (20) @(negedge clock);
                if (!busy || sent >= pkt.size()) begin
                    errors++;
                    $display("Fail at %0t: sender not stalled by a full FIFO", $time);
                end
                @(posedge clock);
                collect(1);
            end
        join
        check_err(1'b0, "after a stalled packet");
    endtask

    task automatic read_timeout();
        build_packet(2'd2, 5);
        send_packet();
        @(negedge clock);
        if (!vld_out_2) begin
            errors++;
            $display("Fail at %0t: vld_out_2 low with data waiting", $time);
        end
        repeat (40) @(negedge clock);
        if (vld_out_2) begin
            errors++;
            $display("Fail at %0t: vld_out_2 still high after 40 unread cycles", $time);
        end
        @(posedge clock);
        build_packet(2'd2, 6);
        send_packet();
        collect(2);
        check_err(1'b0, "after a packet following a flush");
    endtask

    task automatic bad_address();
        logic [7:0] b;
        rand_byte(b);
        put_byte(1'b1, {b[7:2], 2'b11});
        packet_valid <= 1'b0;
        data_in      <= '0;
        repeat (12) begin
            @(negedge clock);
            if (busy || vld_out_0 || vld_out_1 || vld_out_2) begin
                errors++;
                $display("Fail at %0t: header with address 3 was not ignored", $time);
            end
        end
        @(posedge clock);
        build_packet(2'd1, 5);
        send_packet();
        collect(1);
        check_err(1'b0, "after a packet following address 3");
    endtask

    initial begin
        clock        = 1'b0;
        resetn       = 1'b0;
        packet_valid = 1'b0;
        data_in      = '0;
        read_enb_0   = 1'b0;
        read_enb_1   = 1'b0;
        read_enb_2   = 1'b0;
        lfsr         = 16'd40012;
        errors       = 0;
        sent         = 0;
        repeat (2) @(posedge clock);
        resetn <= 1'b1;
        @(negedge clock);
        if (busy || err || vld_out_0 || vld_out_1 || vld_out_2 ||
            data_out_0 !== '0 || data_out_1 !== '0 || data_out_2 !== '0) begin
            errors++;
            $display("Fail at %0t: outputs not idle after reset", $time);
        end
        @(posedge clock);
        route_each_port();
        bad_parity();
        back_pressure();
        read_timeout();
        bad_address();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: router.f
src/router_pkg.sv
src/router_fifo.sv
src/router_port_watch.sv
src/router_sync.sv
src/router_register.sv
src/router_fsm.sv
src/router_top.sv
verification/router_tb.sv
